/* hw/rv_pipe_macros.svh */
// Widths, register count, reset PC and instruction field positions for rv_pipe.
// Included by the package and by every RTL file that uses them.
`ifndef RV_PIPE_MACROS_SVH
`define RV_PIPE_MACROS_SVH

`define RV_XLEN        32
`define RV_REG_IDX_W   5
`define RV_NUM_REGS    32
`define RV_IMM_W       12
`define RV_OPCODE_W    7
`define RV_RESET_PC    32'h0000_0000
`define RV_INSTR_BYTES 32'd4

// Instruction field positions
`define RV_F_OPCODE    6:0
`define RV_F_RD        11:7
`define RV_F_FUNCT3    14:12
`define RV_F_RS1       19:15
`define RV_F_RS2       24:20
`define RV_F_FUNCT7    31:25
`define RV_F_IMM_I     31:20

`endif

/* hw/rv_pipe_pkg.sv */
// Shared types of the rv_pipe core.
// Import with rv_pipe_pkg::* in the module header.
`default_nettype none

`include "rv_pipe_macros.svh"

package rv_pipe_pkg;

  typedef logic [`RV_XLEN-1:0]      word_t;
  typedef logic [`RV_XLEN-1:0]      addr_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`RV_IMM_W-1:0]     imm_t;

  // Major opcodes of the supported subset
  typedef enum logic [`RV_OPCODE_W-1:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_AND = 2'b10,
    ALU_OR  = 2'b11
  } alu_op_e;

  // Instruction port handshake states
  typedef enum logic [1:0] {
    FS_IDLE    = 2'b00,
    FS_REQ     = 2'b01,
    FS_RELEASE = 2'b10
  } fetch_state_e;

endpackage

`default_nettype wire

/* hw/register_file.sv */
// 32 x 32 integer register file with two combinational read ports.
// The clocked write port is fed from the execute register; x0 reads as zero.
`default_nettype none

`include "rv_pipe_macros.svh"

module register_file (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`RV_REG_IDX_W-1:0] rd_idx_a,
  input  logic [`RV_REG_IDX_W-1:0] rd_idx_b,
  output logic [`RV_XLEN-1:0]      rd_data_a,
  output logic [`RV_XLEN-1:0]      rd_data_b,
  input  logic                     wr_en,
  input  logic [`RV_REG_IDX_W-1:0] wr_idx,
  input  logic [`RV_XLEN-1:0]      wr_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `RV_NUM_REGS; i++)
        regs[i] <= '0;
    end
    // Writes to x0 are dropped
    else if (wr_en && (wr_idx != '0))
      regs[wr_idx] <= wr_data;
  end

  // No bypass of a same-cycle write, the hazard unit stalls instead
  assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
// Fetch stage: PC, four-phase instruction port master and fetch register.
// Holds under a decode stall; a redirect reloads the PC and drops data in flight.
`default_nettype none

`include "rv_pipe_macros.svh"

module fetch_stage
  import rv_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  stall,
  input  logic  redirect,
  input  addr_t redirect_pc,
  output logic  imem_req,
  output addr_t imem_addr,
  input  logic  imem_ack,
  input  word_t imem_data,
  output logic  f_valid,
  output addr_t f_pc,
  output word_t f_instr
);

  fetch_state_e state;
  addr_t        pc;
  addr_t        pc_next;
  logic         discard;
  logic         accept;
  logic         start_ok;
  logic         load;

  // Data is taken off the port once it can be stored or is to be thrown away
  assign accept   = (state == FS_REQ) && imem_ack && (!stall || redirect || discard);
  assign load     = accept && !discard && !redirect;
  assign start_ok = !stall || redirect;
  assign imem_req = (state == FS_REQ);

  always_comb
  begin
    if (redirect)
      pc_next = redirect_pc;
    else if (accept && !discard)
      pc_next = pc + `RV_INSTR_BYTES;
    else
      pc_next = pc;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= FS_IDLE;
      pc        <= `RV_RESET_PC;
      imem_addr <= `RV_RESET_PC;
      discard   <= 1'b0;
    end
    else
    begin
      pc <= pc_next;
      case (state)
        FS_IDLE:
        begin
          if (start_ok)
          begin
            state     <= FS_REQ;
            imem_addr <= pc_next;
          end
        end
        FS_REQ:
        begin
          if (accept)
            state <= FS_RELEASE;
        end
        FS_RELEASE:
        begin
          // Next request only once ack is seen low
          if (!imem_ack)
          begin
            state     <= start_ok ? FS_REQ : FS_IDLE;
            imem_addr <= pc_next;
          end
        end
        default: state <= FS_IDLE;
      endcase
      // Request outstanding across a redirect returns stale data
      if (accept)
        discard <= 1'b0;
      else if (redirect && (state == FS_REQ))
        discard <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      f_valid <= 1'b0;
    else if (redirect)
      f_valid <= 1'b0;
    else if (load)
      f_valid <= 1'b1;
    else if (!stall)
      f_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      f_pc    <= imem_addr;
      f_instr <= imem_data;
    end
  end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
// Decode stage: control decode, immediate extension, RAW hazard stall and
// the decode register. Register operands are read combinationally.
`default_nettype none

`include "rv_pipe_macros.svh"

module decode_stage
  import rv_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     f_valid,
  input  addr_t    f_pc,
  input  word_t    f_instr,
  output reg_idx_t rf_idx_a,
  output reg_idx_t rf_idx_b,
  input  word_t    rf_data_a,
  input  word_t    rf_data_b,
  input  logic     redirect,
  input  reg_idx_t ex_rd,
  input  logic     ex_reg_write,
  output logic     stall,
  output logic     d_valid,
  output addr_t    d_pc,
  output word_t    d_rs1_data,
  output word_t    d_rs2_data,
  output word_t    d_imm,
  output reg_idx_t d_rd,
  output alu_op_e  d_alu_op,
  output logic     d_use_imm,
  output logic     d_reg_write,
  output logic     d_branch,
  output addr_t    d_br_offset
);

  opcode_e    opcode;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_t       imm_i;
  word_t      imm_i_ext;
  addr_t      imm_b_ext;
  alu_op_e    alu_op;
  logic       reg_write;
  logic       branch;
  logic       use_imm;
  logic       use_rs1;
  logic       use_rs2;
  logic       hit_a;
  logic       hit_b;
  logic       advance;

  assign opcode   = opcode_e'(f_instr[`RV_F_OPCODE]);
  assign rs1      = f_instr[`RV_F_RS1];
  assign rs2      = f_instr[`RV_F_RS2];
  assign funct3   = f_instr[`RV_F_FUNCT3];
  assign funct7   = f_instr[`RV_F_FUNCT7];
  assign rf_idx_a = rs1;
  assign rf_idx_b = rs2;

  assign imm_i     = f_instr[`RV_F_IMM_I];
  assign imm_i_ext = {{(`RV_XLEN - `RV_IMM_W){imm_i[`RV_IMM_W-1]}}, imm_i};
  // B-type offset, bit 0 is always zero
  assign imm_b_ext = {{(`RV_XLEN - 13){f_instr[31]}}, f_instr[31], f_instr[7],
                      f_instr[30:25], f_instr[11:8], 1'b0};

  // Unsupported encodings fall through as no-ops
  always_comb
  begin
    alu_op    = ALU_ADD;
    reg_write = 1'b0;
    branch    = 1'b0;
    use_imm   = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (opcode)
      OP_REG:
      begin
        reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: alu_op = ALU_AND;
          {7'b0000000, 3'b110}: alu_op = ALU_OR;
          default:              reg_write = 1'b0;
        endcase
        use_rs1 = reg_write;
        use_rs2 = reg_write;
      end
      OP_IMM:
      begin
        // ADDI only
        reg_write = (funct3 == 3'b000);
        use_imm   = 1'b1;
        use_rs1   = reg_write;
      end
      OP_BRANCH:
      begin
        // BEQ compares through a subtract
        branch  = (funct3 == 3'b000);
        alu_op  = ALU_SUB;
        use_rs1 = branch;
        use_rs2 = branch;
      end
      default: reg_write = 1'b0;
    endcase
  end

  // Producer still in the decode register or in the execute register
  assign hit_a = use_rs1 && (rs1 != '0) &&
                 ((d_valid && d_reg_write && (d_rd == rs1)) || (ex_reg_write && (ex_rd == rs1)));
  assign hit_b = use_rs2 && (rs2 != '0) &&
                 ((d_valid && d_reg_write && (d_rd == rs2)) || (ex_reg_write && (ex_rd == rs2)));

  assign stall   = f_valid && (hit_a || hit_b);
  assign advance = f_valid && !stall && !redirect;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      d_valid     <= 1'b0;
      d_reg_write <= 1'b0;
      d_branch    <= 1'b0;
    end
    else
    begin
      // Bubble on stall or redirect
      d_valid     <= advance;
      d_reg_write <= advance && reg_write;
      d_branch    <= advance && branch;
    end
  end

  always_ff @(posedge clk)
  begin
    if (advance)
    begin
      d_pc        <= f_pc;
      d_rs1_data  <= rf_data_a;
      d_rs2_data  <= rf_data_b;
      d_imm       <= imm_i_ext;
      d_rd        <= f_instr[`RV_F_RD];
      d_alu_op    <= alu_op;
      d_use_imm   <= use_imm;
      d_br_offset <= imm_b_ext;
    end
  end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
// Execute stage: operand select, ALU, BEQ resolution and the execute register.
// The execute register is the write-back stage and feeds the hazard check.
`default_nettype none

module execute_stage
  import rv_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     d_valid,
  input  addr_t    d_pc,
  input  word_t    d_rs1_data,
  input  word_t    d_rs2_data,
  input  word_t    d_imm,
  input  reg_idx_t d_rd,
  input  alu_op_e  d_alu_op,
  input  logic     d_use_imm,
  input  logic     d_reg_write,
  input  logic     d_branch,
  input  addr_t    d_br_offset,
  output logic     redirect,
  output addr_t    redirect_pc,
  output reg_idx_t ex_rd,
  output logic     ex_reg_write,
  output logic     wb_valid,
  output reg_idx_t wb_idx,
  output word_t    wb_data
);

  word_t operand_b;
  word_t alu_result;
  word_t ex_data;
  logic  alu_zero;

  assign operand_b = d_use_imm ? d_imm : d_rs2_data;

  always_comb
  begin
    case (d_alu_op)
      ALU_ADD: alu_result = d_rs1_data + operand_b;
      ALU_SUB: alu_result = d_rs1_data - operand_b;
      ALU_AND: alu_result = d_rs1_data & operand_b;
      ALU_OR:  alu_result = d_rs1_data | operand_b;
      default: alu_result = '0;
    endcase
  end

  // Taken BEQ when rs1 - rs2 is zero
  assign alu_zero    = (alu_result == '0);
  assign redirect    = d_valid && d_branch && alu_zero;
  assign redirect_pc = d_pc + d_br_offset;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ex_reg_write <= 1'b0;
    else
      ex_reg_write <= d_valid && d_reg_write && (d_rd != '0);
  end

  always_ff @(posedge clk)
  begin
    if (d_valid)
    begin
      ex_rd   <= d_rd;
      ex_data <= alu_result;
    end
  end

  assign wb_valid = ex_reg_write;
  assign wb_idx   = ex_rd;
  assign wb_data  = ex_data;

endmodule

`default_nettype wire

/* hw/rv_pipe.sv */
// Top of the rv_pipe core: fetch, decode and execute around the register file.
// Instructions arrive over the four-phase imem port; results leave on wb_*.
`default_nettype none

module rv_pipe
  import rv_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  output logic     imem_req,
  output addr_t    imem_addr,
  input  logic     imem_ack,
  input  word_t    imem_data,
  output logic     wb_valid,
  output reg_idx_t wb_idx,
  output word_t    wb_data
);

  logic     f_valid;
  addr_t    f_pc;
  word_t    f_instr;
  logic     stall;
  logic     redirect;
  addr_t    redirect_pc;
  reg_idx_t rf_idx_a;
  reg_idx_t rf_idx_b;
  word_t    rf_data_a;
  word_t    rf_data_b;
  logic     d_valid;
  addr_t    d_pc;
  word_t    d_rs1_data;
  word_t    d_rs2_data;
  word_t    d_imm;
  reg_idx_t d_rd;
  alu_op_e  d_alu_op;
  logic     d_use_imm;
  logic     d_reg_write;
  logic     d_branch;
  addr_t    d_br_offset;
  reg_idx_t ex_rd;
  logic     ex_reg_write;

  fetch_stage u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_ack    (imem_ack),
    .imem_data   (imem_data),
    .f_valid     (f_valid),
    .f_pc        (f_pc),
    .f_instr     (f_instr)
  );

  decode_stage u_decode (
    .clk          (clk),
    .arst_n       (arst_n),
    .f_valid      (f_valid),
    .f_pc         (f_pc),
    .f_instr      (f_instr),
    .rf_idx_a     (rf_idx_a),
    .rf_idx_b     (rf_idx_b),
    .rf_data_a    (rf_data_a),
    .rf_data_b    (rf_data_b),
    .redirect     (redirect),
    .ex_rd        (ex_rd),
    .ex_reg_write (ex_reg_write),
    .stall        (stall),
    .d_valid      (d_valid),
    .d_pc         (d_pc),
    .d_rs1_data   (d_rs1_data),
    .d_rs2_data   (d_rs2_data),
    .d_imm        (d_imm),
    .d_rd         (d_rd),
    .d_alu_op     (d_alu_op),
    .d_use_imm    (d_use_imm),
    .d_reg_write  (d_reg_write),
    .d_branch     (d_branch),
    .d_br_offset  (d_br_offset)
  );

  execute_stage u_execute (
    .clk          (clk),
    .arst_n       (arst_n),
    .d_valid      (d_valid),
    .d_pc         (d_pc),
    .d_rs1_data   (d_rs1_data),
    .d_rs2_data   (d_rs2_data),
    .d_imm        (d_imm),
    .d_rd         (d_rd),
    .d_alu_op     (d_alu_op),
    .d_use_imm    (d_use_imm),
    .d_reg_write  (d_reg_write),
    .d_branch     (d_branch),
    .d_br_offset  (d_br_offset),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .ex_rd        (ex_rd),
    .ex_reg_write (ex_reg_write),
    .wb_valid     (wb_valid),
    .wb_idx       (wb_idx),
    .wb_data      (wb_data)
  );

  // Written from the execute register
  register_file u_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_idx_a  (rf_idx_a),
    .rd_idx_b  (rf_idx_b),
    .rd_data_a (rf_data_a),
    .rd_data_b (rf_data_b),
    .wr_en     (wb_valid),
    .wr_idx    (wb_idx),
    .wr_data   (wb_data)
  );

endmodule

`default_nettype wire

/* testbench/imem_responder.sv */
// Instruction memory model on the four-phase imem port of rv_pipe.
// Acks each request with the word the testbench supplies and releases ack
// after random delays, and checks the handshake rules with immediate assertions.
`default_nettype none

module imem_responder
  import rv_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  imem_req,
  input  addr_t imem_addr,
  output logic  imem_ack,
  output word_t imem_data,
  input  word_t mem_word,
  output int    proto_errors
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'h270b_d3ae;

  int    wait_left;
  logic  prev_req;
  logic  prev_ack;
  addr_t prev_addr;

  // Ack rises 0 to 5 cycles after req and falls 0 to 3 cycles after req drops
  initial
  begin
    void'($urandom(SEED));
    imem_ack     = 1'b0;
    imem_data    = '0;
    proto_errors = 0;
    wait_left    = -1;
    forever
    begin
      @(posedge clk);
      #2;
      if (!arst_n)
      begin
        imem_ack  = 1'b0;
        wait_left = -1;
      end
      else if (imem_req && !imem_ack)
      begin
        if (wait_left < 0)
          wait_left = $urandom_range(5, 0);
        if (wait_left == 0)
        begin
          imem_ack  = 1'b1;
          imem_data = mem_word;
          wait_left = -1;
        end
        else
          wait_left--;
      end
      else if (!imem_req && imem_ack)
      begin
        if (wait_left < 0)
          wait_left = $urandom_range(3, 0);
        if (wait_left == 0)
        begin
          imem_ack  = 1'b0;
          wait_left = -1;
        end
        else
          wait_left--;
      end
    end
  end

  // Sampled mid-cycle against the previous sample
  always @(negedge clk)
  begin
    if (!arst_n)
    begin
      assert (!imem_req)
      else
      begin
        proto_errors++;
        $display("imem_req is high during reset");
      end
    end
    else
    begin
      if (prev_req && imem_req)
      begin
        assert (imem_addr == prev_addr)
        else
        begin
          proto_errors++;
          $display("imem_addr changed from %08h to %08h while imem_req was high",
                   prev_addr, imem_addr);
        end
      end
      if (prev_req && !imem_req)
      begin
        assert (prev_ack)
        else
        begin
          proto_errors++;
          $display("imem_req dropped before imem_ack rose");
        end
      end
      if (!prev_req && imem_req)
      begin
        assert (!prev_ack)
        else
        begin
          proto_errors++;
          $display("imem_req rose while imem_ack was still high");
        end
      end
    end
    prev_req  = imem_req;
    prev_ack  = imem_ack;
    prev_addr = imem_addr;
  end

endmodule

`default_nettype wire

/* testbench/rv_pipe_tb.sv */
// Testbench for rv_pipe that runs a fixed program image through the core and
// compares every write-back, in order, with a sequential ISA model.
// The imem responder beside the DUT checks the instruction handshake.
`default_nettype none

module rv_pipe_tb
  import rv_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // ADDI x0, x0, 0
  localparam word_t NOP_WORD      = 32'h0000_0013;
  localparam int    WB_TIMEOUT    = 2000;
  localparam int    DRAIN_TIMEOUT = 200;
  localparam int    MAX_STEPS     = 256;

  logic     clk;
  logic     arst_n;
  logic     imem_req;
  addr_t    imem_addr;
  logic     imem_ack;
  word_t    imem_data;
  logic     wb_valid;
  reg_idx_t wb_idx;
  word_t    wb_data;
  word_t    mem_word;
  int       proto_errors;

  word_t    prog [32];
  string    prog_name [32];
  int       prog_len;

  reg_idx_t exp_idx [$];
  word_t    exp_data [$];
  int       exp_slot [$];
  int       wb_count;
  int       check_errors;
  int       timeouts;
  int       cycles;

  rv_pipe DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .imem_data (imem_data),
    .wb_valid  (wb_valid),
    .wb_idx    (wb_idx),
    .wb_data   (wb_data)
  );

  imem_responder u_imem (
    .clk          (clk),
    .arst_n       (arst_n),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_ack     (imem_ack),
    .imem_data    (imem_data),
    .mem_word     (mem_word),
    .proto_errors (proto_errors)
  );

  always #10 clk = ~clk;

  // Words past the end of the image read as a no-op
  assign mem_word = (imem_addr[31:2] < prog_len) ? prog[imem_addr[31:2]] : NOP_WORD;

  function automatic word_t r_type(input logic [6:0] funct7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] funct3,
                                   input reg_idx_t rd);
    return {funct7, rs2, rs1, funct3, rd, OP_REG};
  endfunction

  function automatic word_t addi_word(input reg_idx_t rd, input reg_idx_t rs1, input int imm);
    return {imm[11:0], rs1, 3'b000, rd, OP_IMM};
  endfunction

  function automatic word_t beq_word(input reg_idx_t rs1, input reg_idx_t rs2, input int offset);
    logic [12:0] o;
    o = offset[12:0];
    return {o[12], o[10:5], rs2, rs1, 3'b000, o[4:1], o[11], OP_BRANCH};
  endfunction

  task automatic append_instr(input word_t w, input string name);
    prog[prog_len]      = w;
    prog_name[prog_len] = name;
    prog_len++;
  endtask

  task automatic build_program();
    append_instr(addi_word(5'd1, 5'd0, 5), "addi_seed");
    append_instr(addi_word(5'd2, 5'd0, 12), "addi_seed");
    // Each result feeds the next instruction directly
    append_instr(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3), "add_dep");
    append_instr(r_type(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4), "sub_dep");
    append_instr(r_type(7'b0000000, 5'd1, 5'd3, 3'b111, 5'd5), "and_reg");
    append_instr(r_type(7'b0000000, 5'd1, 5'd4, 3'b110, 5'd6), "or_reg");
    append_instr(addi_word(5'd7, 5'd0, -7), "addi_neg");
    append_instr(addi_word(5'd8, 5'd7, -2048), "addi_neg");
    append_instr(addi_word(5'd0, 5'd1, 99), "x0_write");
    append_instr(r_type(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd9), "x0_read");
    append_instr(beq_word(5'd1, 5'd2, 8), "beq_not_taken");
    append_instr(addi_word(5'd10, 5'd0, 1), "beq_fall");
    append_instr(beq_word(5'd1, 5'd1, 12), "beq_taken");
    append_instr(addi_word(5'd11, 5'd0, 111), "beq_skip");
    append_instr(addi_word(5'd12, 5'd0, 222), "beq_skip");
    append_instr(r_type(7'b0100000, 5'd7, 5'd10, 3'b000, 5'd13), "beq_target");
    append_instr(r_type(7'b0000000, 5'd8, 5'd13, 3'b110, 5'd14), "or_dep");
    append_instr(r_type(7'b0000000, 5'd6, 5'd14, 3'b111, 5'd15), "and_dep");
  endtask

  // Sequential ISA model that retires one instruction at a time
  task automatic run_reference();
    word_t    regs [32];
    word_t    w;
    word_t    a;
    word_t    b;
    word_t    res;
    reg_idx_t rd;
    logic     wr;
    int       pc;
    int       next_pc;
    int       off;
    int       steps;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    pc    = 0;
    steps = 0;
    while ((pc >= 0) && (pc < prog_len) && (steps < MAX_STEPS))
    begin
      w       = prog[pc];
      a       = regs[w[19:15]];
      b       = regs[w[24:20]];
      rd      = w[11:7];
      wr      = 1'b0;
      res     = '0;
      next_pc = pc + 1;
      case (w[6:0])
        OP_REG:
        begin
          wr = 1'b1;
          case ({w[31:25], w[14:12]})
            10'b0000000_000: res = a + b;
            10'b0100000_000: res = a - b;
            10'b0000000_111: res = a & b;
            10'b0000000_110: res = a | b;
            default:         wr  = 1'b0;
          endcase
        end
        OP_IMM:
        begin
          wr  = (w[14:12] == 3'b000);
          res = a + {{20{w[31]}}, w[31:20]};
        end
        OP_BRANCH:
        begin
          // Byte offset over four-byte instructions
          off = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
          if ((w[14:12] == 3'b000) && (a == b))
            next_pc = pc + off / 4;
        end
        default: wr = 1'b0;
      endcase
      // x0 stays zero for later reads
      if (wr && (rd != '0))
      begin
        regs[rd] = res;
        exp_idx.push_back(rd);
        exp_data.push_back(res);
        exp_slot.push_back(pc);
      end
      pc = next_pc;
      steps++;
    end
  endtask

  always @(negedge clk)
  begin
    if (!arst_n)
    begin
      assert (!wb_valid)
      else
      begin
        check_errors++;
        $display("wb_valid is high during reset");
      end
    end
    else if (wb_valid)
    begin
      assert (wb_idx != '0)
      else
      begin
        check_errors++;
        $display("Write-back to x0 appeared on wb_valid");
      end
      if (wb_count < exp_idx.size())
      begin
        assert ((wb_idx == exp_idx[wb_count]) && (wb_data == exp_data[wb_count]))
        else
        begin
          check_errors++;
          $display("Mismatch %s: expected x%0d = %08h, actual x%0d = %08h",
                   prog_name[exp_slot[wb_count]], exp_idx[wb_count], exp_data[wb_count],
                   wb_idx, wb_data);
        end
      end
      else
      begin
        check_errors++;
        $display("Unexpected write-back to x%0d after the last expected one", wb_idx);
      end
      wb_count++;
    end
  end

  initial
  begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    prog_len     = 0;
    wb_count     = 0;
    check_errors = 0;
    timeouts     = 0;
    build_program();
    run_reference();
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;

    cycles = 0;
    while ((wb_count < exp_idx.size()) && (cycles < WB_TIMEOUT))
    begin
      @(negedge clk);
      cycles++;
    end
    if (wb_count < exp_idx.size())
    begin
      timeouts++;
      $display("Timeout with %0d of %0d write-backs seen", wb_count, exp_idx.size());
    end

    // Fetch runs past the image so a stray late write would still show
    cycles = 0;
    while (!(imem_req && (imem_addr >= (prog_len + 3) * 4)) && (cycles < DRAIN_TIMEOUT))
    begin
      @(negedge clk);
      cycles++;
    end
    if (!(imem_req && (imem_addr >= (prog_len + 3) * 4)))
    begin
      timeouts++;
      $display("Timeout while fetch did not run past the end of the program");
    end

    @(negedge clk);
    $display("Write-backs %0d of %0d, check errors %0d, handshake errors %0d, timeouts %0d",
             wb_count, exp_idx.size(), check_errors, proto_errors, timeouts);
    if ((check_errors + proto_errors + timeouts) == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_pipe.f */
+incdir+hw
hw/rv_pipe_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/rv_pipe.sv
testbench/imem_responder.sv
testbench/rv_pipe_tb.sv
